/* coll_pkg.sv */
// Types and table layout shared by the collision engine blocks
// Only the header layout with an 11-bit list 0 start is supported
// Request addresses are always 11 bits wide; the RAM uses the low ADDR_W bits
package coll_pkg;

    localparam int BUS_AW = 11;           // Request address width

    // CPU side RAM write
    typedef struct packed {
        logic              we;
        logic [BUS_AW-1:0] addr;
        logic [7:0]        data;
    } cpu_req_t;

    // Engine side RAM access, read every cycle, write on we
    typedef struct packed {
        logic              we;
        logic [BUS_AW-1:0] addr;
        logic [7:0]        wdata;
    } mem_req_t;

    // Header byte offsets from address 0
    localparam int HDR_END0_HI = 0;       // Bits 2:0 only
    localparam int HDR_END0_LO = 1;
    localparam int HDR_END1    = 2;       // List 1 end, 8 bits
    localparam int HDR_CMASK   = 3;       // List 0 enable mask
    localparam int HDR_HMASK   = 4;       // List 1 enable mask
    localparam int HDR_POS0_HI = 5;       // Bits 2:0 only
    localparam int HDR_POS0_LO = 6;
    localparam int HDR_START1  = 7;       // List 1 start, low 256 bytes

    // Object record layout
    localparam int OBJ_FLAGS  = 0;
    localparam int OBJ_HALF_W = 1;
    localparam int OBJ_HALF_H = 2;
    localparam int OBJ_X      = 3;
    localparam int OBJ_Y      = 4;
    localparam int OBJ_BYTES  = 5;        // Record stride

    // Flag bits
    localparam int FLAG_HIT   = 4;        // Set in both records on overlap
    localparam int FLAG_SHARE = 2;        // Copied from list 1 into list 0

    // Enabled cycles of low irq_n after a walk
    localparam logic [5:0] IRQ_HOLD = 6'd63;

endpackage

/* coll_ram.sv */
// Dual-port byte RAM, both read ports registered (one cycle latency)
// Port A takes CPU writes and reads at a_addr, port B serves the engine
// Same address written on both ports in one cycle keeps the port B byte
// Read during write on a port returns the old byte
module coll_ram #(
    parameter int ADDR_W = 11
) (
    input  logic               clk,
    input  coll_pkg::cpu_req_t a_req,
    input  logic [ADDR_W-1:0]  a_addr,
    output logic [7:0]         a_q,
    input  coll_pkg::mem_req_t b_req,
    output logic [7:0]         b_q
);

    logic [7:0]        mem [2**ADDR_W];
    logic [ADDR_W-1:0] a_wr_addr;
    logic [ADDR_W-1:0] b_addr;

    // Upper request bits ignored for small tables
    assign a_wr_addr = a_req.addr[ADDR_W-1:0];
    assign b_addr    = b_req.addr[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (a_req.we) mem[a_wr_addr] <= a_req.data;
        if (b_req.we) mem[b_addr] <= b_req.wdata;    // Last one wins, B over A
        a_q <= mem[a_addr];
        b_q <= mem[b_addr];
    end

endmodule

/* coll_cpu_port.sv */
// CPU bus decoder for the collision RAM
// Writes need cs, cpu_we and bk together; writes with bk low are dropped
// Read data shows up on cpu_din two clocks after the request
// Table writes while busy is high corrupt the walk
module coll_cpu_port #(
    parameter int ADDR_W = 11
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cs,
    input  logic               cpu_we,
    input  logic               bk,
    input  logic [ADDR_W-1:0]  cpu_addr,
    input  logic [7:0]         cpu_dout,
    input  logic               busy,
    input  logic [7:0]         ram_q,
    output coll_pkg::cpu_req_t wr_req,
    output logic [7:0]         cpu_din
);
    import coll_pkg::*;

    logic rd_v;     // Read issued last cycle
    logic rd_bk;    // Its bank select

    // Write goes straight to RAM port A
    assign wr_req.we   = cs & cpu_we & bk;
    assign wr_req.addr = BUS_AW'(cpu_addr);
    assign wr_req.data = cpu_dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_v  <= 1'b0;
            rd_bk <= 1'b0;
        end else begin
            rd_v  <= cs & ~cpu_we;
            rd_bk <= bk;        // Match RAM latency
        end
    end

    // RAM byte or status, bit 0 is busy
    always_ff @(posedge clk) begin
        if (rd_v) cpu_din <= rd_bk ? ram_q : {7'd0, busy};
    end

endmodule

/* coll_ctrl.sv */
// Start, busy and interrupt control
// A rising start edge sets busy regardless of cen
// irq_n stays low for IRQ_HOLD enabled cycles after done
// busy drops on the first clock that sees irq_n low
module coll_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic start,
    input  logic done,
    output logic run,
    output logic busy,
    output logic irq_n
);
    import coll_pkg::*;

    logic       start_l;
    logic [5:0] hold_cnt;

    // Engine stalls while the interrupt is held
    assign run = busy & (hold_cnt == 6'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l <= 1'b0;
            busy    <= 1'b0;
        end else begin
            start_l <= start;
            if (start && !start_l) busy <= 1'b1;
            if (!irq_n) busy <= 1'b0;   // Clear wins
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_cnt <= 6'd0;
            irq_n    <= 1'b1;
        end else begin
            if (done) begin
                hold_cnt <= IRQ_HOLD;   // done only pulses with cen
            end else if (cen && hold_cnt != 6'd0) begin
                hold_cnt <= hold_cnt - 6'd1;
            end
            // Low from the cycle after the load until the count ends
            if (cen) irq_n <= (hold_cnt == 6'd0);
        end
    end

endmodule

/* coll_engine.sv */
// Collision walk over list 0 against list 1
// Address for the next byte is presented one state ahead, RAM latency is 1
// Advances only while cen and run are both high
// List 1 pointers are 8 bits and wrap, so list 1 sits in the first 256 bytes
// Box edges use 8-bit wrapping arithmetic and strict unsigned compares
module coll_engine #(
    parameter int ADDR_W = 11
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               run,
    input  logic [7:0]         ram_q,
    output coll_pkg::mem_req_t eng_req,
    output logic               done
);
    import coll_pkg::*;

    typedef enum logic [4:0] {
        S_IDLE, S_HDR,
        S_O_FLAGS, S_O_X, S_O_Y, S_O_HW, S_O_HH,
        S_I_FLAGS, S_I_X, S_I_Y, S_I_HW, S_I_HH,
        S_W0, S_W1, S_I_NEXT, S_O_NEXT, S_FIN
    } state_t;

    state_t            state;
    logic [2:0]        hdr_idx;             // Header byte being read
    logic [10:0]       end0, pos0;
    logic [7:0]        end1, start1, pos1;
    logic [7:0]        cmask, hmask;
    logic [7:0]        flag0, flag1;        // flag0 latched once per outer step
    logic [7:0]        x0, y0, l0, r0, t0, b0;
    logic [7:0]        x1, y1, l1, r1;
    logic [7:0]        t1, b1;              // Straight from the half height byte
    logic              hit;
    logic [ADDR_W-1:0] req_addr;

    // Record byte address
    function automatic logic [ADDR_W-1:0] rec(input logic [10:0] base, input int off);
        return ADDR_W'(base + 11'(off));
    endfunction

    assign t1  = y1 - ram_q;
    assign b1  = y1 + ram_q;
    assign hit = (l1 < r0) && (l0 < r1) && (t1 < b0) && (t0 < b1);

    assign done = cen & run & (state == S_FIN);

    // Address for the byte the next state consumes
    always_comb begin
        req_addr = '0;
        case (state)
            S_IDLE:    req_addr = ADDR_W'(HDR_END0_HI);
            S_HDR:     req_addr = (int'(hdr_idx) == HDR_START1) ? rec(pos0, OBJ_FLAGS)
                                                                : ADDR_W'(hdr_idx + 3'd1);
            S_O_FLAGS: req_addr = rec(pos0, OBJ_X);
            S_O_X:     req_addr = rec(pos0, OBJ_Y);
            S_O_Y:     req_addr = rec(pos0, OBJ_HALF_W);
            S_O_HW:    req_addr = rec(pos0, OBJ_HALF_H);
            S_O_HH:    req_addr = rec({3'd0, start1}, OBJ_FLAGS);
            S_I_FLAGS: req_addr = rec({3'd0, pos1}, OBJ_X);
            S_I_X:     req_addr = rec({3'd0, pos1}, OBJ_Y);
            S_I_Y:     req_addr = rec({3'd0, pos1}, OBJ_HALF_W);
            S_I_HW:    req_addr = rec({3'd0, pos1}, OBJ_HALF_H);
            S_W0:      req_addr = rec(pos0, OBJ_FLAGS);          // List 0 write-back
            S_W1:      req_addr = rec({3'd0, pos1}, OBJ_FLAGS);  // List 1 write-back
            S_I_NEXT:  req_addr = rec({3'd0, pos1}, OBJ_FLAGS);
            S_O_NEXT:  req_addr = rec(pos0, OBJ_FLAGS);
            default:   req_addr = '0;
        endcase
    end

    always_comb begin
        eng_req.addr  = BUS_AW'(req_addr);
        eng_req.we    = cen & run & ((state == S_W0) | (state == S_W1));
        eng_req.wdata = flag1;
        eng_req.wdata[FLAG_HIT] = 1'b1;
        if (state == S_W0) begin
            eng_req.wdata = flag0;
            eng_req.wdata[FLAG_HIT]   = 1'b1;
            eng_req.wdata[FLAG_SHARE] = flag0[FLAG_SHARE] | flag1[FLAG_SHARE];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            hdr_idx <= 3'd0;
        end else if (cen && run) begin
            case (state)
                S_IDLE: begin
                    hdr_idx <= 3'd0;
                    state   <= S_HDR;
                end
                S_HDR: begin
                    case (int'(hdr_idx))
                        HDR_END0_HI: end0[10:8] <= ram_q[2:0];
                        HDR_END0_LO: end0[7:0]  <= ram_q;
                        HDR_END1:    end1       <= ram_q;
                        HDR_CMASK:   cmask      <= ram_q;
                        HDR_HMASK:   hmask      <= ram_q;
                        HDR_POS0_HI: pos0[10:8] <= ram_q[2:0];
                        HDR_POS0_LO: pos0[7:0]  <= ram_q;
                        default:     start1     <= ram_q;
                    endcase
                    hdr_idx <= hdr_idx + 3'd1;
                    if (int'(hdr_idx) == HDR_START1) state <= S_O_FLAGS;
                end
                S_O_FLAGS: begin
                    flag0 <= ram_q;
                    if ((ram_q & cmask) == 8'd0) begin    // Masked out
                        pos0  <= pos0 + 11'(OBJ_BYTES);
                        state <= S_O_NEXT;
                    end else begin
                        state <= S_O_X;
                    end
                end
                S_O_X: begin x0 <= ram_q; state <= S_O_Y; end
                S_O_Y: begin y0 <= ram_q; state <= S_O_HW; end
                S_O_HW: begin
                    l0    <= x0 - ram_q;
                    r0    <= x0 + ram_q;
                    state <= S_O_HH;
                end
                S_O_HH: begin
                    t0    <= y0 - ram_q;
                    b0    <= y0 + ram_q;
                    pos1  <= start1;                // Inner walk restarts
                    state <= S_I_FLAGS;
                end
                S_I_FLAGS: begin
                    flag1 <= ram_q;
                    if ((ram_q & hmask) == 8'd0) begin
                        pos1  <= pos1 + 8'(OBJ_BYTES);
                        state <= S_I_NEXT;
                    end else begin
                        state <= S_I_X;
                    end
                end
                S_I_X: begin x1 <= ram_q; state <= S_I_Y; end
                S_I_Y: begin y1 <= ram_q; state <= S_I_HW; end
                S_I_HW: begin
                    l1    <= x1 - ram_q;
                    r1    <= x1 + ram_q;
                    state <= S_I_HH;
                end
                S_I_HH: begin
                    if (hit) begin
                        state <= S_W0;
                    end else begin
                        pos1  <= pos1 + 8'(OBJ_BYTES);
                        state <= S_I_NEXT;
                    end
                end
                S_W0: state <= S_W1;
                S_W1: begin
                    pos1  <= pos1 + 8'(OBJ_BYTES);
                    state <= S_I_NEXT;
                end
                S_I_NEXT: begin
                    if (pos1 < end1) begin
                        state <= S_I_FLAGS;
                    end else begin
                        pos0  <= pos0 + 11'(OBJ_BYTES);   // Inner list done
                        state <= S_O_NEXT;
                    end
                end
                S_O_NEXT: state <= (pos0 < end0) ? S_O_FLAGS : S_FIN;
                default:  state <= S_IDLE;                // S_FIN, done pulses here
            endcase
        end
    end

endmodule

/* coll_top.sv */
// Collision engine top level
// CPU writes the table with bk high, reads with bk low return status
// Do not write the table while busy is high
// ADDR_W below 11 shrinks the RAM, upper address bits are then ignored
module coll_top #(
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cs,
    input  logic              cpu_we,
    input  logic              bk,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [7:0]        cpu_dout,
    input  logic              start,
    output logic [7:0]        cpu_din,
    output logic              irq_n,
    output logic              busy
);
    import coll_pkg::*;

    cpu_req_t   wr_req;
    mem_req_t   eng_req;
    logic [7:0] ram_a_q;
    logic [7:0] ram_b_q;
    logic       run;
    logic       done;

    coll_cpu_port #(.ADDR_W(ADDR_W)) u_port (
        .clk     (clk),
        .rst     (rst),
        .cs      (cs),
        .cpu_we  (cpu_we),
        .bk      (bk),
        .cpu_addr(cpu_addr),
        .cpu_dout(cpu_dout),
        .busy    (busy),
        .ram_q   (ram_a_q),
        .wr_req  (wr_req),
        .cpu_din (cpu_din)
    );

    coll_ctrl u_ctrl (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .start(start),
        .done (done),
        .run  (run),
        .busy (busy),
        .irq_n(irq_n)
    );

    coll_engine #(.ADDR_W(ADDR_W)) u_engine (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .run    (run),
        .ram_q  (ram_b_q),
        .eng_req(eng_req),
        .done   (done)
    );

    // CPU reads straight from the bus address
    coll_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk   (clk),
        .a_req (wr_req),
        .a_addr(cpu_addr),
        .a_q   (ram_a_q),
        .b_req (eng_req),
        .b_q   (ram_b_q)
    );

endmodule

/* tb_clk.sv */
// Clock and power-on reset for the testbench
// 8 ns period, reset held for 16 rising edges
module tb_clk (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;            // Released on an edge
    end

endmodule

/* coll_tb.sv */
// Testbench for the collision engine, cen tied high, ADDR_W at 11
// Table kept in the low 192 bytes: header at 0, list 0 from 16, list 1 from 128
// A walk model updates the table image, the RAM is then read back and compared
module coll_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import coll_pkg::*;

    localparam int CMP_TOP    = 192;    // Bytes compared after a walk
    localparam int WALK_LIMIT = 4000;   // Cycles allowed until irq_n falls

    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  got;
    } rb_t;

    logic        clk;
    logic        rst;
    logic        cs;
    logic        cpu_we;
    logic        bk;
    logic        start;
    logic [10:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic [7:0]  cpu_din;
    logic        irq_n;
    logic        busy;

    logic [7:0]  img [256];             // Expected RAM image
    logic [31:0] rng = 32'd67;
    rb_t         rb_q [$];              // Read-back bytes for the compare process
    int          n_err = 0;
    int          n_checks = 0;
    int          n_tests = 0;
    int          err_mark = 0;

    tb_clk u_clk (
        .clk(clk),
        .rst(rst)
    );

    coll_top #(.ADDR_W(11)) uut (
        .clk     (clk),
        .rst     (rst),
        .cen     (1'b1),
        .cs      (cs),
        .cpu_we  (cpu_we),
        .bk      (bk),
        .cpu_addr(cpu_addr),
        .cpu_dout(cpu_dout),
        .start   (start),
        .cpu_din (cpu_din),
        .irq_n   (irq_n),
        .busy    (busy)
    );

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Walk rules applied to img in place
    function automatic void walk_model();
        logic [10:0] end0, pos0;
        logic [7:0]  end1, pos1, cmask, hmask, f0, f1;
        logic [7:0]  l0, r0, t0, b0, l1, r1, t1, b1;
        int          a0, a1;
        end0  = {img[HDR_END0_HI][2:0], img[HDR_END0_LO]};
        pos0  = {img[HDR_POS0_HI][2:0], img[HDR_POS0_LO]};
        end1  = img[HDR_END1];
        cmask = img[HDR_CMASK];
        hmask = img[HDR_HMASK];
        do begin
            a0 = int'(pos0);
            f0 = img[a0];               // Held for the whole outer step
            if ((f0 & cmask) != 8'd0) begin
                l0 = img[a0 + OBJ_X] - img[a0 + OBJ_HALF_W];
                r0 = img[a0 + OBJ_X] + img[a0 + OBJ_HALF_W];
                t0 = img[a0 + OBJ_Y] - img[a0 + OBJ_HALF_H];
                b0 = img[a0 + OBJ_Y] + img[a0 + OBJ_HALF_H];
                pos1 = img[HDR_START1];
                do begin
                    a1 = int'(pos1);
                    f1 = img[a1];       // Fresh read, may hold earlier hits
                    if ((f1 & hmask) != 8'd0) begin
                        l1 = img[a1 + OBJ_X] - img[a1 + OBJ_HALF_W];
                        r1 = img[a1 + OBJ_X] + img[a1 + OBJ_HALF_W];
                        t1 = img[a1 + OBJ_Y] - img[a1 + OBJ_HALF_H];
                        b1 = img[a1 + OBJ_Y] + img[a1 + OBJ_HALF_H];
                        if (l1 < r0 && l0 < r1 && t1 < b0 && t0 < b1) begin
                            img[a0] = f0 | 8'(1 << FLAG_HIT) | (f1 & 8'(1 << FLAG_SHARE));
                            img[a1] = f1 | 8'(1 << FLAG_HIT);
                        end
                    end
                    pos1 = pos1 + 8'(OBJ_BYTES);    // 8-bit wrap
                end while (pos1 < end1);
            end
            pos0 = pos0 + 11'(OBJ_BYTES);
        end while (pos0 < end0);
    endfunction

    task automatic give_up(input string why);
        $display("TIMEOUT at %0t: %s", $time, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
            n_err++;
        end
    endtask

    task automatic cpu_write(input int a, input logic [7:0] v, input logic bank);
        @(posedge clk);
        cs       <= 1'b1;
        cpu_we   <= 1'b1;
        bk       <= bank;
        cpu_addr <= 11'(a);
        cpu_dout <= v;
        @(posedge clk);         // Written on this edge
        cs       <= 1'b0;
        cpu_we   <= 1'b0;
    endtask

    // Data lands on cpu_din two edges after the request
    task automatic cpu_read(input int a, input logic bank, output logic [7:0] v);
        @(posedge clk);
        cs       <= 1'b1;
        cpu_we   <= 1'b0;
        bk       <= bank;
        cpu_addr <= 11'(a);
        @(posedge clk);
        cs       <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        v = cpu_din;
    endtask

    task automatic write_byte(input int a, input logic [7:0] v);
        img[a] = v;
        cpu_write(a, v, 1'b1);
    endtask

    task automatic put_rec(input int a, input logic [7:0] flags, input logic [7:0] hw,
                           input logic [7:0] hh, input logic [7:0] x, input logic [7:0] y);
        write_byte(a + OBJ_FLAGS, flags);
        write_byte(a + OBJ_HALF_W, hw);
        write_byte(a + OBJ_HALF_H, hh);
        write_byte(a + OBJ_X, x);
        write_byte(a + OBJ_Y, y);
    endtask

    task automatic put_header(input int e0, input int e1, input logic [7:0] cm,
                              input logic [7:0] hm, input int p0, input int s1);
        write_byte(HDR_END0_HI, 8'((e0 >> 8) & 7));
        write_byte(HDR_END0_LO, 8'(e0));
        write_byte(HDR_END1, 8'(e1));
        write_byte(HDR_CMASK, cm);
        write_byte(HDR_HMASK, hm);
        write_byte(HDR_POS0_HI, 8'((p0 >> 8) & 7));
        write_byte(HDR_POS0_LO, 8'(p0));
        write_byte(HDR_START1, 8'(s1));
    endtask

    // Start pulse, busy status mid-walk, then the interrupt window
    task automatic run_walk();
        logic [7:0] st;
        int         cyc;
        int         low;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cpu_read(0, 1'b0, st);
        check_val("status", st, 8'h01);
        cyc = 0;
        while (irq_n) begin
            @(negedge clk);
            cyc++;
            if (cyc > WALK_LIMIT) give_up("irq_n never fell, the walk did not end");
        end
        low = 0;
        while (!irq_n) begin
            low++;
            @(negedge clk);
            if (low > 200) give_up("irq_n stuck low");
        end
        check_val("irq_n low cycles", 8'(low), 8'd63);
        check_val("busy", {7'd0, busy}, 8'h00);
    endtask

    // Queue the whole compared region, then let the compare process drain it
    task automatic read_back();
        logic [7:0] v;
        rb_t        rb;
        int         cyc;
        for (int a = 0; a < CMP_TOP; a++) begin
            cpu_read(a, 1'b1, v);
            rb.addr = 11'(a);
            rb.got  = v;
            rb_q.push_back(rb);
        end
        cyc = 0;
        while (rb_q.size() != 0) begin
            @(negedge clk);
            cyc++;
            if (cyc > 10) give_up("compare queue did not drain");
        end
    endtask

    task automatic walk_and_compare();
        run_walk();
        walk_model();
        read_back();
    endtask

    // A overlaps B, C only touches D on the x edge
    task automatic load_pair_table();
        put_rec(16, 8'h01, 8'd4, 8'd4, 8'd50, 8'd50);
        put_rec(21, 8'h01, 8'd4, 8'd4, 8'd100, 8'd100);
        put_rec(128, 8'h05, 8'd4, 8'd4, 8'd54, 8'd52);      // Carries the share bit
        put_rec(133, 8'h01, 8'd4, 8'd4, 8'd108, 8'd100);
        put_header(26, 138, 8'h01, 8'h01, 16, 128);
    endtask

    task automatic test_done(input string name);
        n_tests++;
        if (n_err == err_mark) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, name, n_err - err_mark);
        end
        err_mark = n_err;
    endtask

    initial begin : compare
        rb_t rb;
        forever begin
            @(posedge clk);
            while (rb_q.size() > 0) begin
                rb = rb_q.pop_front();
                n_checks++;
                assert (rb.got === img[int'(rb.addr)]) else begin
                    $display("CHECK FAILED t=%0t ram[%0d] got %h exp %h",
                             $time, rb.addr, rb.got, img[int'(rb.addr)]);
                    n_err++;
                end
            end
        end
    end

    initial begin : main
        logic [7:0] v;
        int         cyc;
        int         n0, n1, b0, b1;
        cs       <= 1'b0;
        cpu_we   <= 1'b0;
        bk       <= 1'b0;
        start    <= 1'b0;
        cpu_addr <= '0;
        cpu_dout <= '0;
        @(negedge clk);
        cyc = 0;
        while (rst) begin
            @(negedge clk);
            cyc++;
            if (cyc > 100) give_up("reset never released");
        end

        check_val("irq_n", {7'd0, irq_n}, 8'h01);
        check_val("busy", {7'd0, busy}, 8'h00);
        cpu_read(0, 1'b0, v);
        check_val("status", v, 8'h00);
        test_done("reset state");

        for (int a = 0; a < CMP_TOP; a++) begin
            write_byte(a, 8'(a ^ (a >> 3)));
        end

        load_pair_table();
        walk_and_compare();
        cpu_read(16, 1'b1, v);
        check_val("list 0 flags", v, 8'h15);    // Hit plus share
        cpu_read(133, 1'b1, v);
        check_val("list 1 flags", v, 8'h01);    // Touching edges only
        test_done("overlap and touch");

        put_rec(16, 8'h20, 8'd8, 8'd8, 8'd80, 8'd80);
        put_rec(21, 8'h40, 8'd8, 8'd8, 8'd80, 8'd80);
        put_rec(128, 8'h20, 8'd8, 8'd8, 8'd80, 8'd80);
        put_rec(133, 8'h40, 8'd8, 8'd8, 8'd80, 8'd80);
        put_header(26, 138, 8'h20, 8'h40, 16, 128);
        walk_and_compare();
        cpu_read(16, 1'b1, v);
        check_val("list 0 flags", v, 8'h30);
        write_byte(HDR_CMASK, 8'h40);           // Swap which records take part
        write_byte(HDR_HMASK, 8'h20);
        walk_and_compare();
        cpu_read(21, 1'b1, v);
        check_val("list 0 flags", v, 8'h50);
        test_done("mask skips");

        for (int t = 0; t < 12; t++) begin
            n0 = 1 + int'(xorshift() % 32'd6);
            n1 = 1 + int'(xorshift() % 32'd6);
            b0 = 16 + int'(xorshift() % 32'd24);
            b1 = 128 + int'(xorshift() % 32'd32);
            for (int i = 0; i < n0; i++) begin
                put_rec(b0 + i * OBJ_BYTES, 8'(xorshift()), 8'(xorshift() % 32'd40),
                        8'(xorshift() % 32'd40), 8'(xorshift()), 8'(xorshift()));
            end
            for (int i = 0; i < n1; i++) begin
                put_rec(b1 + i * OBJ_BYTES, 8'(xorshift()), 8'(xorshift() % 32'd40),
                        8'(xorshift() % 32'd40), 8'(xorshift()), 8'(xorshift()));
            end
            put_header(b0 + n0 * OBJ_BYTES, b1 + n1 * OBJ_BYTES, 8'(xorshift()),
                       8'(xorshift()), b0, b1);
            walk_and_compare();
        end
        test_done("random tables");

        load_pair_table();
        walk_and_compare();                     // Status and irq window checked inside
        test_done("busy and irq timing");

        cpu_write(40, ~img[40], 1'b0);          // Dropped by the port
        cpu_read(40, 1'b1, v);
        check_val("ram[40]", v, img[40]);
        read_back();
        test_done("bank low write");

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
        if (n_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* coll_top.f */
coll_pkg.sv
coll_ram.sv
coll_cpu_port.sv
coll_ctrl.sv
coll_engine.sv
coll_top.sv
tb_clk.sv
coll_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the collision engine testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module coll_tb \
    -f coll_top.f -o coll_sim > build.log 2>&1 \
    && ./obj_dir/coll_sim > sim.log 2>&1 \
    || echo "Build or run stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
